// File: eviction_macros.svh
`ifndef EVICTION_MACROS_SVH
`define EVICTION_MACROS_SVH

// buffer geometry
`define EVB_ENTRIES 8
`define EVB_IDX_W 3

// tree pseudo-LRU, one bit per internal node of an eight-leaf tree
`define EVB_PLRU_W 7

`endif

// File: lc3b_types.sv
`include "eviction_macros.svh"

package lc3b_types;

    typedef logic [15:0] lc3b_word;       // byte address
    typedef logic [127:0] lc3b_cacheline; // one 16 byte line

    // bit 0 is the root, bits 1..2 pick within a half, bits 3..6 within a pair
    typedef logic [`EVB_PLRU_W-1:0] lc3b_7b_plru;

    typedef struct packed {
        logic          valid;
        logic          dirty;
        lc3b_word      addr;
        lc3b_cacheline data;
    } lc3b_eviction_array_entry;

    typedef enum logic [2:0] {
        s_idle,
        s_write_store, // store cache line into the chosen way
        s_evict,       // write victim line out to memory
        s_read_hit,
        s_miss_req,    // forward read to memory
        s_miss_resp
    } evb_state_t;

endpackage : lc3b_types

// File: eviction_ctrl_if.sv
`timescale 1ns/1ns
`include "eviction_macros.svh"

interface eviction_ctrl_if;
    import lc3b_types::*;

    // controller to datapath
    logic                   load_d;
    logic                   valid;
    logic                   dirty;
    logic                   load_lru;
    lc3b_7b_plru            lru_in;
    logic [`EVB_IDX_W-1:0]  index_sel;
    logic                   read_src_sel;   // 1 picks the miss latch
    logic [`EVB_IDX_W:0]    smemaddr_sel;   // 8 picks the cache address

    // datapath to controller
    logic [`EVB_ENTRIES-1:0] hits;
    logic [`EVB_ENTRIES-1:0] entry_valid;
    lc3b_7b_plru             lru_out;

    modport ctrl (
        output load_d, valid, dirty, load_lru, lru_in, index_sel, read_src_sel, smemaddr_sel,
        input  hits, entry_valid, lru_out
    );

    modport dp (
        input  load_d, valid, dirty, load_lru, lru_in, index_sel, read_src_sel, smemaddr_sel,
        output hits, entry_valid, lru_out
    );

endinterface : eviction_ctrl_if

// File: array_fully_associative.sv
`timescale 1ns/1ns
`include "eviction_macros.svh"

module array_fully_associative (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  logic                                                   write,
    input  logic [`EVB_IDX_W-1:0]                                  index,
    input  lc3b_types::lc3b_eviction_array_entry                   datain,
    output lc3b_types::lc3b_eviction_array_entry [`EVB_ENTRIES-1:0] dataout
);
    import lc3b_types::*;

    logic [`EVB_ENTRIES-1:0] valid_q;
    logic [`EVB_ENTRIES-1:0] dirty_q;
    lc3b_word                addr_q [`EVB_ENTRIES];
    lc3b_cacheline           data_q [`EVB_ENTRIES];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (write) begin
            valid_q[index] <= datain.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            dirty_q[index] <= datain.dirty;
            addr_q[index]  <= datain.addr;
            data_q[index]  <= datain.data;
        end
    end

    always_comb begin
        for (int i = 0; i < `EVB_ENTRIES; i++) begin
            dataout[i].valid = valid_q[i];
            dataout[i].dirty = dirty_q[i];
            dataout[i].addr  = addr_q[i];
            dataout[i].data  = data_q[i];
        end
    end

endmodule : array_fully_associative

// File: plru_tree.sv
`timescale 1ns/1ns
`include "eviction_macros.svh"

module plru_tree (
    input  lc3b_types::lc3b_7b_plru lru,
    input  logic [`EVB_IDX_W-1:0]   way,
    output lc3b_types::lc3b_7b_plru lru_next,
    output logic [`EVB_IDX_W-1:0]   victim
);

    // node indices on the path of the accessed way
    logic [1:0] acc_half;
    logic [2:0] acc_pair;

    // node indices while walking toward the victim
    logic       vic_root;
    logic       vic_mid;
    logic       vic_leaf;
    logic [1:0] vic_half;
    logic [2:0] vic_pair;

    assign acc_half = 2'd1 + {1'b0, way[2]};
    assign acc_pair = 3'd3 + {1'b0, way[2:1]};

    // each node on the path records the side just used, so it points away from it
    always_comb begin
        lru_next           = lru;
        lru_next[0]        = way[2];
        lru_next[acc_half] = way[1];
        lru_next[acc_pair] = way[0];
    end

    // a 0 node means left was more recent, so go right
    always_comb begin
        vic_root = ~lru[0];
        vic_half = 2'd1 + {1'b0, vic_root};
        vic_mid  = ~lru[vic_half];
        vic_pair = 3'd3 + {1'b0, vic_root, vic_mid};
        vic_leaf = ~lru[vic_pair];
    end

    assign victim = {vic_root, vic_mid, vic_leaf};

endmodule : plru_tree

// File: eviction_buffer_datapath.sv
`timescale 1ns/1ns
`include "eviction_macros.svh"

module eviction_buffer_datapath (
    input  logic                     clk,
    input  logic                     rst,
    eviction_ctrl_if.dp              ctl,

    // cache side
    input  lc3b_types::lc3b_word      buf_mem_address,
    input  lc3b_types::lc3b_cacheline buf_mem_wdata,
    output lc3b_types::lc3b_cacheline buf_mem_rdata,

    // memory side
    input  lc3b_types::lc3b_cacheline super_mem_rdata,
    output lc3b_types::lc3b_word      super_mem_address,
    output lc3b_types::lc3b_cacheline super_mem_wdata
);
    import lc3b_types::*;

    lc3b_eviction_array_entry                    d_in;
    lc3b_eviction_array_entry [`EVB_ENTRIES-1:0] d_out;
    lc3b_cacheline                               way_data;
    lc3b_cacheline                               miss_data;
    lc3b_7b_plru                                 lru_q;

    assign d_in = '{
        valid: ctl.valid,
        dirty: ctl.dirty,
        addr:  buf_mem_address,
        data:  buf_mem_wdata
    };

    array_fully_associative u_array (
        .clk     (clk),
        .rst     (rst),
        .write   (ctl.load_d),
        .index   (ctl.index_sel),
        .datain  (d_in),
        .dataout (d_out)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            lru_q <= '0;
        end else if (ctl.load_lru) begin
            lru_q <= ctl.lru_in;
        end
    end

    assign ctl.lru_out = lru_q;

    always_ff @(posedge clk) begin
        miss_data <= super_mem_rdata; // holds the line from the resp edge
    end

    assign way_data        = d_out[ctl.index_sel].data;
    assign super_mem_wdata = way_data;
    assign buf_mem_rdata   = ctl.read_src_sel ? miss_data : way_data;

    always_comb begin
        if (ctl.smemaddr_sel < `EVB_ENTRIES) begin
            super_mem_address = d_out[ctl.smemaddr_sel[`EVB_IDX_W-1:0]].addr;
        end else if (ctl.smemaddr_sel == `EVB_ENTRIES) begin
            super_mem_address = buf_mem_address; // miss forward
        end else begin
            super_mem_address = '0;
        end
    end

    always_comb begin
        for (int i = 0; i < `EVB_ENTRIES; i++) begin
            ctl.hits[i]        = d_out[i].valid & (d_out[i].addr == buf_mem_address);
            ctl.entry_valid[i] = d_out[i].valid;
        end
    end

endmodule : eviction_buffer_datapath

// File: eviction_buffer_control.sv
`timescale 1ns/1ns
`include "eviction_macros.svh"

module eviction_buffer_control (
    input  logic          clk,
    input  logic          rst,
    eviction_ctrl_if.ctrl ctl,
    input  logic          buf_mem_read,
    input  logic          buf_mem_write,
    input  logic          super_mem_resp,
    output logic          buf_mem_resp,
    output logic          super_mem_read,
    output logic          super_mem_write
);
    import lc3b_types::*;

    localparam logic [`EVB_IDX_W:0] sel_cache_addr = `EVB_ENTRIES;

    evb_state_t            state;
    evb_state_t            state_next;
    logic [`EVB_IDX_W-1:0] way_q;
    logic [`EVB_IDX_W-1:0] way_sel;
    logic [`EVB_IDX_W-1:0] hit_way;
    logic [`EVB_IDX_W-1:0] free_way;
    logic [`EVB_IDX_W-1:0] victim;
    logic                  hit_any;
    logic                  free_any;
    lc3b_7b_plru           lru_next;

    // lowest index with its bit set
    function automatic logic [`EVB_IDX_W-1:0] lowest_set(input logic [`EVB_ENTRIES-1:0] v);
        logic [`EVB_IDX_W-1:0] idx;
        idx = '0;
        for (int i = `EVB_ENTRIES - 1; i >= 0; i--) begin
            if (v[i]) begin
                idx = i[`EVB_IDX_W-1:0];
            end
        end
        return idx;
    endfunction

    plru_tree u_plru (
        .lru      (ctl.lru_out),
        .way      (way_q),
        .lru_next (lru_next),
        .victim   (victim)
    );

    assign hit_any  = |ctl.hits;
    assign hit_way  = lowest_set(ctl.hits);
    assign free_any = ~&ctl.entry_valid;
    assign free_way = lowest_set(~ctl.entry_valid);

    always_comb begin
        state_next = state;
        way_sel    = way_q;
        case (state)
            s_idle: begin
                if (buf_mem_write) begin
                    if (hit_any) begin
                        way_sel    = hit_way;  // overwrite in place
                        state_next = s_write_store;
                    end else if (free_any) begin
                        way_sel    = free_way;
                        state_next = s_write_store;
                    end else begin
                        way_sel    = victim;
                        state_next = s_evict;
                    end
                end else if (buf_mem_read) begin
                    if (hit_any) begin
                        way_sel    = hit_way;
                        state_next = s_read_hit;
                    end else begin
                        state_next = s_miss_req;
                    end
                end
            end
            s_write_store: state_next = s_idle;
            s_evict: begin
                if (super_mem_resp) begin
                    state_next = s_write_store; // victim is out, reuse its way
                end
            end
            s_read_hit: state_next = s_idle;
            s_miss_req: begin
                if (super_mem_resp) begin
                    state_next = s_miss_resp;
                end
            end
            s_miss_resp: state_next = s_idle;
            default: state_next = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle) begin
            way_q <= way_sel;
        end
    end

    always_comb begin
        ctl.load_d       = 1'b0;
        ctl.valid        = 1'b0;
        ctl.dirty        = 1'b0;
        ctl.load_lru     = 1'b0;
        ctl.lru_in       = lru_next;
        ctl.index_sel    = way_q;
        ctl.read_src_sel = 1'b0;
        ctl.smemaddr_sel = {1'b0, way_q};
        buf_mem_resp     = 1'b0;
        super_mem_read   = 1'b0;
        super_mem_write  = 1'b0;
        case (state)
            s_write_store: begin
                ctl.load_d   = 1'b1;
                ctl.valid    = 1'b1;
                ctl.dirty    = 1'b1; // buffered lines are always dirty
                ctl.load_lru = 1'b1;
                buf_mem_resp = 1'b1;
            end
            s_evict: super_mem_write = 1'b1;
            s_read_hit: begin
                ctl.load_lru = 1'b1;
                buf_mem_resp = 1'b1;
            end
            s_miss_req: begin
                super_mem_read   = 1'b1;
                ctl.smemaddr_sel = sel_cache_addr;
            end
            s_miss_resp: begin
                ctl.read_src_sel = 1'b1;
                buf_mem_resp     = 1'b1;
            end
            default: ;
        endcase
    end

endmodule : eviction_buffer_control

// File: eviction_buffer.sv
`timescale 1ns/1ns

module eviction_buffer (
    input  logic                      clk,
    input  logic                      rst,

    // cache side
    input  logic                      buf_mem_read,
    input  logic                      buf_mem_write,
    input  lc3b_types::lc3b_word      buf_mem_address,
    input  lc3b_types::lc3b_cacheline buf_mem_wdata,
    output lc3b_types::lc3b_cacheline buf_mem_rdata,
    output logic                      buf_mem_resp,

    // memory side
    output logic                      super_mem_read,
    output logic                      super_mem_write,
    output lc3b_types::lc3b_word      super_mem_address,
    output lc3b_types::lc3b_cacheline super_mem_wdata,
    input  lc3b_types::lc3b_cacheline super_mem_rdata,
    input  logic                      super_mem_resp
);

    eviction_ctrl_if ctl ();

    eviction_buffer_control u_control (
        .clk             (clk),
        .rst             (rst),
        .ctl             (ctl.ctrl),
        .buf_mem_read    (buf_mem_read),
        .buf_mem_write   (buf_mem_write),
        .super_mem_resp  (super_mem_resp),
        .buf_mem_resp    (buf_mem_resp),
        .super_mem_read  (super_mem_read),
        .super_mem_write (super_mem_write)
    );

    eviction_buffer_datapath u_datapath (
        .clk               (clk),
        .rst               (rst),
        .ctl               (ctl.dp),
        .buf_mem_address   (buf_mem_address),
        .buf_mem_wdata     (buf_mem_wdata),
        .buf_mem_rdata     (buf_mem_rdata),
        .super_mem_rdata   (super_mem_rdata),
        .super_mem_address (super_mem_address),
        .super_mem_wdata   (super_mem_wdata)
    );

endmodule : eviction_buffer

// File: eviction_buffer_chk.sv
`timescale 1ns/1ns

module eviction_buffer_chk (
    input logic clk,
    input logic rst,
    input logic buf_mem_read,
    input logic buf_mem_write,
    input logic buf_mem_resp,
    input logic super_mem_read,
    input logic super_mem_write,
    input logic super_mem_resp
);

    // only one memory request at a time
    no_dual_request: assert property (@(posedge clk) disable iff (rst)
        !(super_mem_read && super_mem_write))
        else $error("super_mem_read and super_mem_write high together");

    resp_one_cycle: assert property (@(posedge clk) disable iff (rst)
        buf_mem_resp |=> !buf_mem_resp)
        else $error("buf_mem_resp longer than one cycle");

    read_holds: assert property (@(posedge clk) disable iff (rst)
        super_mem_read && !super_mem_resp |=> super_mem_read)
        else $error("super_mem_read dropped before super_mem_resp");

    write_holds: assert property (@(posedge clk) disable iff (rst)
        super_mem_write && !super_mem_resp |=> super_mem_write)
        else $error("super_mem_write dropped before super_mem_resp");

    // the cache request was up in the cycle that produced resp
    resp_needs_request: assert property (@(posedge clk) disable iff (rst)
        buf_mem_resp |-> $past(buf_mem_read || buf_mem_write))
        else $error("buf_mem_resp without a cache request");

endmodule : eviction_buffer_chk

bind eviction_buffer eviction_buffer_chk chk (
    .clk             (clk),
    .rst             (rst),
    .buf_mem_read    (buf_mem_read),
    .buf_mem_write   (buf_mem_write),
    .buf_mem_resp    (buf_mem_resp),
    .super_mem_read  (super_mem_read),
    .super_mem_write (super_mem_write),
    .super_mem_resp  (super_mem_resp)
);

// File: eviction_buffer_tb.sv
`timescale 1ns/1ns
`include "eviction_macros.svh"

module eviction_buffer_tb;
    import lc3b_types::*;

    localparam int num_ops    = 3 + 11 + 12 + 300; // directed tests plus the random mix
    localparam int timeout_ns = (num_ops * 20 + 30) * 100;

    logic          clk;
    logic          rst;
    logic          buf_mem_read;
    logic          buf_mem_write;
    lc3b_word      buf_mem_address;
    lc3b_cacheline buf_mem_wdata;
    lc3b_cacheline buf_mem_rdata;
    logic          buf_mem_resp;
    logic          super_mem_read;
    logic          super_mem_write;
    lc3b_word      super_mem_address;
    lc3b_cacheline super_mem_wdata;
    lc3b_cacheline super_mem_rdata;
    logic          super_mem_resp;

    int error_count;

    // memory model state and what it saw
    lc3b_cacheline mem [lc3b_word];
    lc3b_word      obs_rd_addr_q [$];
    lc3b_word      obs_wb_addr_q [$];
    lc3b_cacheline obs_wb_data_q [$];

    // reference model state and expectations
    logic          ref_valid [`EVB_ENTRIES];
    lc3b_word      ref_addr [`EVB_ENTRIES];
    lc3b_cacheline ref_data [`EVB_ENTRIES];
    lc3b_7b_plru   ref_tree;
    lc3b_cacheline ref_mem [lc3b_word];
    bit            exp_is_read_q [$];
    lc3b_cacheline exp_rdata_q [$];
    lc3b_word      exp_rd_addr_q [$];
    lc3b_word      exp_wb_addr_q [$];
    lc3b_cacheline exp_wb_data_q [$];

    eviction_buffer uut (.*);

    always #50 clk = ~clk;

    // untouched memory reads back a pattern of the whole address
    function automatic lc3b_cacheline mem_fill(input lc3b_word a);
        return {4{~a, a}};
    endfunction

    // heap layout with the children of node n at 2n+1 (left) and 2n+2 (right)
    function automatic int tree_victim(input lc3b_7b_plru t);
        int n;
        n = 0;
        for (int lvl = 0; lvl < 3; lvl++) begin
            n = t[n] ? 2 * n + 1 : 2 * n + 2;
        end
        return n - 7;
    endfunction

    function automatic lc3b_7b_plru tree_touch(input lc3b_7b_plru t, input int way);
        int n;
        int d;
        n = 0;
        for (int lvl = 2; lvl >= 0; lvl--) begin
            d = (way >> lvl) & 1;
            t[n] = d[0]; // point away from the used side
            n = 2 * n + 1 + d;
        end
        return t;
    endfunction

    function automatic void ref_access(input bit is_write, input lc3b_word addr,
                                       input lc3b_cacheline wdata,
                                       output lc3b_cacheline rdata, output bit evict,
                                       output lc3b_word wb_addr, output lc3b_cacheline wb_data,
                                       output bit miss);
        int way;
        way = -1;
        evict = 0;
        miss = 0;
        rdata = '0;
        wb_addr = '0;
        wb_data = '0;
        for (int i = 0; i < `EVB_ENTRIES; i++) begin
            if (way < 0 && ref_valid[i] && ref_addr[i] == addr) way = i;
        end
        if (is_write) begin
            for (int i = 0; i < `EVB_ENTRIES; i++) begin
                if (way < 0 && !ref_valid[i]) way = i;
            end
            if (way < 0) begin
                way = tree_victim(ref_tree);
                evict = 1;
                wb_addr = ref_addr[way];
                wb_data = ref_data[way];
                ref_mem[wb_addr] = wb_data;
            end
            ref_valid[way] = 1;
            ref_addr[way] = addr;
            ref_data[way] = wdata;
            ref_tree = tree_touch(ref_tree, way);
        end else if (way >= 0) begin
            rdata = ref_data[way];
            ref_tree = tree_touch(ref_tree, way);
        end else begin
            miss = 1;
            rdata = ref_mem.exists(addr) ? ref_mem[addr] : mem_fill(addr);
        end
    endfunction

    task automatic apply_reset();
        @(negedge clk);
        rst = 1;
        repeat (5) @(negedge clk);
        rst = 0;
        for (int i = 0; i < `EVB_ENTRIES; i++) ref_valid[i] = 0;
        ref_tree = '0;
    endtask

    task automatic run_op(input bit is_write, input lc3b_word addr, input lc3b_cacheline data);
        lc3b_cacheline rd;
        lc3b_cacheline wbd;
        lc3b_word      wba;
        bit            evict;
        bit            miss;
        @(negedge clk);
        ref_access(is_write, addr, data, rd, evict, wba, wbd, miss);
        exp_is_read_q.push_back(!is_write);
        exp_rdata_q.push_back(rd);
        if (miss) exp_rd_addr_q.push_back(addr);
        if (evict) begin
            exp_wb_addr_q.push_back(wba);
            exp_wb_data_q.push_back(wbd);
        end
        buf_mem_address = addr;
        buf_mem_wdata = data;
        buf_mem_write = is_write;
        buf_mem_read = !is_write;
        @(negedge clk);
        while (!buf_mem_resp) @(negedge clk);
        buf_mem_read = 0; // released inside the resp cycle
        buf_mem_write = 0;
    endtask

    function automatic lc3b_cacheline rand_line();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // memory model with a latency of 1 to 4 cycles
    always begin
        int wait_cycles;
        @(negedge clk);
        if (!rst && (super_mem_read || super_mem_write)) begin
            wait_cycles = $urandom_range(3, 0);
            repeat (wait_cycles) @(negedge clk);
            if (super_mem_write) begin
                mem[super_mem_address] = super_mem_wdata;
                obs_wb_addr_q.push_back(super_mem_address);
                obs_wb_data_q.push_back(super_mem_wdata);
            end else begin
                super_mem_rdata = mem.exists(super_mem_address) ?
                                  mem[super_mem_address] : mem_fill(super_mem_address);
                obs_rd_addr_q.push_back(super_mem_address);
            end
            super_mem_resp = 1;
            @(negedge clk);
            super_mem_resp = 0;
        end
    end

    // compares returned lines and every memory access against the reference
    always @(negedge clk) begin
        bit            is_rd;
        lc3b_cacheline exp_line;
        if (!rst && buf_mem_resp) begin
            if (exp_rdata_q.size() == 0) begin
                error_count++;
                $display("buf_mem_resp arrived with no request outstanding");
            end else begin
                is_rd = exp_is_read_q.pop_front();
                exp_line = exp_rdata_q.pop_front();
                if (is_rd) begin
                    assert (buf_mem_rdata == exp_line) else begin
                        error_count++;
                        $display("Error buf_mem_rdata expected %h got %h",
                                 exp_line, buf_mem_rdata);
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        while (obs_rd_addr_q.size() > 0) begin
            if (exp_rd_addr_q.size() == 0) begin
                error_count++;
                $display("memory read at %h that the reference did not expect",
                         obs_rd_addr_q.pop_front());
            end else begin
                assert (obs_rd_addr_q[0] == exp_rd_addr_q[0]) else begin
                    error_count++;
                    $display("Error super_mem_address expected %h got %h",
                             exp_rd_addr_q[0], obs_rd_addr_q[0]);
                end
                void'(obs_rd_addr_q.pop_front());
                void'(exp_rd_addr_q.pop_front());
            end
        end
        while (obs_wb_addr_q.size() > 0) begin
            if (exp_wb_addr_q.size() == 0) begin
                error_count++;
                $display("write-back to %h that the reference did not expect",
                         obs_wb_addr_q.pop_front());
                void'(obs_wb_data_q.pop_front());
            end else begin
                assert (obs_wb_addr_q[0] == exp_wb_addr_q[0]) else begin
                    error_count++;
                    $display("Error super_mem_address expected %h got %h",
                             exp_wb_addr_q[0], obs_wb_addr_q[0]);
                end
                assert (obs_wb_data_q[0] == exp_wb_data_q[0]) else begin
                    error_count++;
                    $display("Error super_mem_wdata expected %h got %h",
                             exp_wb_data_q[0], obs_wb_data_q[0]);
                end
                void'(obs_wb_addr_q.pop_front());
                void'(obs_wb_data_q.pop_front());
                void'(exp_wb_addr_q.pop_front());
                void'(exp_wb_data_q.pop_front());
            end
        end
    end

    initial begin
        #(timeout_ns);
        $display("Timeout, the DUT stopped answering requests");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        lc3b_word      a;
        lc3b_cacheline line;
        int            v_before;
        void'($urandom(62737));
        clk = 0;
        rst = 1;
        buf_mem_read = 0;
        buf_mem_write = 0;
        buf_mem_address = '0;
        buf_mem_wdata = '0;
        super_mem_rdata = '0;
        super_mem_resp = 0;
        error_count = 0;
        apply_reset();

        // write then read back without memory traffic
        line = rand_line();
        run_op(1, 16'h0100, line);
        run_op(0, 16'h0100, '0);

        // read miss goes to memory
        run_op(0, 16'h0230, '0);

        // overwrite in place and then fill the rest without eviction
        apply_reset();
        run_op(1, 16'h0300, rand_line());
        run_op(1, 16'h0300, rand_line());
        run_op(0, 16'h0300, '0);
        for (int i = 1; i < 8; i++) run_op(1, 16'h0300 + 16'(i * 16), rand_line());
        run_op(0, 16'h0300, '0);

        // eviction of the pseudo-LRU victim as steered by read hits
        apply_reset();
        for (int i = 0; i < 8; i++) run_op(1, 16'h0400 + 16'(i * 16), rand_line());
        v_before = tree_victim(ref_tree);
        run_op(0, ref_addr[v_before], '0);
        run_op(0, 16'h0420, '0);
        run_op(1, 16'h0500, rand_line());
        run_op(0, 16'h0500, '0);

        // random mix over 16 addresses
        apply_reset();
        for (int i = 0; i < 300; i++) begin
            a = 16'h0600 + 16'($urandom_range(15, 0) * 16);
            run_op($urandom_range(1, 0) == 1, a, rand_line());
        end

        repeat (3) @(negedge clk);
        if (exp_rd_addr_q.size() != 0 || exp_wb_addr_q.size() != 0) begin
            error_count++;
            $display("expected memory accesses never happened");
        end
        $display("Errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : eviction_buffer_tb

// File: project.f
+incdir+.
lc3b_types.sv
eviction_ctrl_if.sv
array_fully_associative.sv
plru_tree.sv
eviction_buffer_datapath.sv
eviction_buffer_control.sv
eviction_buffer.sv
eviction_buffer_chk.sv
eviction_buffer_tb.sv

// File: Makefile
TOP = eviction_buffer_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir
